//--- soc_pkg.sv
// Shared bus types, address map and UART state encodings
// HWREG_PAGE selects register space through the upper 16 address bits

package soc_pkg;

    // Bus widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;
    typedef logic [7:0]  byte_t;

    // ########################################################################
    // Address map
    // ########################################################################

    localparam addr_t       MEM_START  = 32'h0000_0000;
    localparam logic [15:0] HWREG_PAGE = 16'hFF00;

    // Register offsets inside the hardware register page
    localparam logic [15:0] REG_UART_DATA   = 16'h0000;
    localparam logic [15:0] REG_UART_STATUS = 16'h0004;

    // Returned by a data read while the receive queue is empty
    localparam word_t RDATA_EMPTY = 32'hFFFF_FFFF;

    // ########################################################################
    // UART state machines
    // ########################################################################

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

//--- ram32.sv
// Word RAM with byte-lane writes, read data one cycle after the request
// WORDS must be a power of two; contents are undefined after power-up

module ram32 import soc_pkg::*; #(
    parameter int unsigned WORDS = 1024
) (
    input  logic  clk_i,
    input  logic  rst_n,
    input  logic  req_i,
    input  logic  we_i,
    input  be_t   be_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output logic  rvalid_o,
    output word_t rdata_o
);

    localparam int unsigned IDX_W = $clog2(WORDS);

    word_t             mem [WORDS];
    logic [IDX_W-1:0]  idx;
    word_t             rdata_q;
    logic              rvalid_q;

    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= mem[idx];
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) begin
                        mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // Decoder upstream must keep requests inside the array
    a_addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_n)
        req_i |-> (addr_i[31:2] < WORDS))
        else $error("ram32: request outside array, addr %h", addr_i);

endmodule

//--- uart_tx.sv
// 8N1 transmitter, LSB first, line idles high
// CLK_FREQ / BAUD_RATE gives the clocks per bit and should be at least 2

module uart_tx import soc_pkg::*; #(
    parameter int unsigned CLK_FREQ  = 100_000_000,
    parameter int unsigned BAUD_RATE = 115200
) (
    input  logic  clk_i,
    input  logic  rst_n,
    input  logic  valid_i,
    input  byte_t data_i,
    output logic  ready_o,
    output logic  tx_o
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);

    tx_state_e         state_q;
    logic [CNT_W-1:0]  baud_cnt_q;
    logic [2:0]        bit_cnt_q;
    byte_t             shift_q;
    logic              bit_done;

    assign bit_done = (baud_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign ready_o  = (state_q == TX_IDLE);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else begin
            if (state_q == TX_IDLE || bit_done) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end

            case (state_q)
                TX_IDLE: begin
                    bit_cnt_q <= '0;
                    if (valid_i) begin
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state_q <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift register, loaded on an accepted byte
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            shift_q <= data_i;
        end else if (state_q == TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            TX_START: tx_o = 1'b0;
            TX_DATA:  tx_o = shift_q[0];
            default:  tx_o = 1'b1;
        endcase
    end

endmodule

//--- uart_rx.sv
// 8N1 receiver with a two-flop synchronizer and mid-bit sampling
// Frames with a low stop bit are dropped; no parity or break detection

module uart_rx import soc_pkg::*; #(
    parameter int unsigned CLK_FREQ  = 100_000_000,
    parameter int unsigned BAUD_RATE = 115200
) (
    input  logic  clk_i,
    input  logic  rst_n,
    input  logic  rx_i,
    output logic  valid_o,
    output byte_t data_o
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);

    logic [1:0]        sync_q;
    logic              rx_s;
    rx_state_e         state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [2:0]        bit_cnt_q;
    byte_t             shift_q;
    logic              valid_q;
    logic              bit_mid;

    assign rx_s    = sync_q[1];
    assign bit_mid = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_i};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    cnt_q     <= '0;
                    bit_cnt_q <= '0;
                    if (!rx_s) begin
                        state_q <= RX_START;
                    end
                end
                // Wait half a bit and confirm the start bit is still low
                RX_START: begin
                    if (cnt_q == CNT_W'(HALF_BIT - 1)) begin
                        cnt_q   <= '0;
                        state_q <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        cnt_q     <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (bit_mid) begin
                        state_q <= RX_IDLE;
                        valid_q <= rx_s;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_mid) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign valid_o = valid_q;
    assign data_o  = shift_q;

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
        valid_o |=> !valid_o)
        else $error("uart_rx: valid_o held for more than one cycle");

endmodule

//--- uart_iface.sv
// UART transmitter and receiver with a receive queue, popped by a read
// When the queue is full a new byte overwrites the newest entry

module uart_iface import soc_pkg::*; #(
    parameter int unsigned CLK_FREQ     = 100_000_000,
    parameter int unsigned BAUD_RATE    = 115200,
    parameter int unsigned RX_QUEUE_LEN = 8
) (
    input  logic  clk_i,
    input  logic  rst_n,

    input  logic  tx_we_i,
    input  byte_t tx_data_i,
    output logic  tx_busy_o,
    input  logic  rx_read_i,
    output logic  rx_valid_o,
    output byte_t rx_data_o,

    input  logic  rx_i,
    output logic  tx_o
);

    localparam int unsigned LAST = RX_QUEUE_LEN - 1;

    logic  tx_ready;
    logic  rx_valid;
    byte_t rx_byte;

    // ########################################################################
    // Serial side
    // ########################################################################

    uart_tx #(
        .CLK_FREQ  ( CLK_FREQ  ),
        .BAUD_RATE ( BAUD_RATE )
    ) i_tx (
        .clk_i     ( clk_i     ),
        .rst_n     ( rst_n     ),
        .valid_i   ( tx_we_i   ),
        .data_i    ( tx_data_i ),
        .ready_o   ( tx_ready  ),
        .tx_o      ( tx_o      )
    );

    assign tx_busy_o = ~tx_ready;

    uart_rx #(
        .CLK_FREQ  ( CLK_FREQ  ),
        .BAUD_RATE ( BAUD_RATE )
    ) i_rx (
        .clk_i     ( clk_i     ),
        .rst_n     ( rst_n     ),
        .rx_i      ( rx_i      ),
        .valid_o   ( rx_valid  ),
        .data_o    ( rx_byte   )
    );

    // ########################################################################
    // Receive queue, slot 0 is the head
    // ########################################################################

    logic [RX_QUEUE_LEN-1:0] q_valid;
    logic [RX_QUEUE_LEN-1:0] q_valid_d;
    byte_t                   q_data [RX_QUEUE_LEN];
    logic [LAST-1:0]         take;
    logic                    pop;

    assign pop = rx_read_i & q_valid[0];

    // A slot takes its upper neighbour when empty, or when the head is popped
    always_comb begin
        for (int i = 0; i < LAST; i++) begin
            take[i] = ~q_valid[i];
        end
        take[0] = take[0] | pop;
    end

    always_comb begin
        q_valid_d = q_valid;
        for (int i = 0; i < LAST; i++) begin
            if (take[i]) begin
                q_valid_d[i]   = q_valid[i+1];
                q_valid_d[i+1] = 1'b0;
            end
        end
        if (rx_valid) begin
            q_valid_d[LAST] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= '0;
        end else begin
            q_valid <= q_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < LAST; i++) begin
            if (take[i]) begin
                q_data[i] <= q_data[i+1];
            end
        end
        if (rx_valid) begin
            q_data[LAST] <= rx_byte;
        end
    end

    assign rx_valid_o = q_valid[0];
    assign rx_data_o  = q_data[0];

    // A pop removes exactly one stored byte, so it never hits an empty queue
    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n)
        pop && !rx_valid |=> $countones(q_valid) + 1 == $past($countones(q_valid)))
        else $error("uart_iface: pop did not remove exactly one entry");

endmodule

//--- hwreg_iface.sv
// Hardware register page: UART data at offset 0x0, status at offset 0x4
// Reading the data register pops the receive queue

module hwreg_iface import soc_pkg::*; #(
    parameter int unsigned CLK_FREQ     = 100_000_000,
    parameter int unsigned BAUD_RATE    = 115200,
    parameter int unsigned RX_QUEUE_LEN = 8
) (
    input  logic        clk_i,
    input  logic        rst_n,
    input  logic        req_i,
    input  logic        we_i,
    input  logic [15:0] addr_i,
    input  word_t       wdata_i,
    output logic        rvalid_o,
    output word_t       rdata_o,

    input  logic        rx_i,
    output logic        tx_o
);

    logic  data_sel;
    logic  tx_we;
    logic  rx_read;
    logic  tx_busy;
    logic  rx_valid;
    byte_t rx_data;
    word_t rdata_q;
    logic  rvalid_q;

    assign data_sel = (addr_i[15:2] == REG_UART_DATA[15:2]);
    assign tx_we    = req_i & we_i & data_sel;
    assign rx_read  = req_i & ~we_i & data_sel;

    uart_iface #(
        .CLK_FREQ     ( CLK_FREQ      ),
        .BAUD_RATE    ( BAUD_RATE     ),
        .RX_QUEUE_LEN ( RX_QUEUE_LEN  )
    ) i_uart (
        .clk_i        ( clk_i         ),
        .rst_n        ( rst_n         ),
        .tx_we_i      ( tx_we         ),
        .tx_data_i    ( wdata_i[7:0]  ),
        .tx_busy_o    ( tx_busy       ),
        .rx_read_i    ( rx_read       ),
        .rx_valid_o   ( rx_valid      ),
        .rx_data_o    ( rx_data       ),
        .rx_i         ( rx_i          ),
        .tx_o         ( tx_o          )
    );

    // Read value is taken in the request cycle, before the pop lands
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            case (addr_i[15:2])
                REG_UART_DATA[15:2]:   rdata_q <= rx_valid ? word_t'(rx_data) : RDATA_EMPTY;
                REG_UART_STATUS[15:2]: rdata_q <= {30'd0, rx_valid, tx_busy};
                default:               rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

//--- demo_sys.sv
// Peripheral system top: RAM at MEM_START, UART registers in HWREG_PAGE
// Every request is answered one cycle later; unmapped addresses raise mem_err_o

module demo_sys import soc_pkg::*; #(
    parameter int unsigned CLK_FREQ     = 100_000_000,
    parameter int unsigned BAUD_RATE    = 115200,
    parameter int unsigned RAM_SIZE     = 262144,
    parameter int unsigned RX_QUEUE_LEN = 8
) (
    input  logic  clk_i,
    input  logic  rst_n,

    input  logic  mem_req_i,
    input  addr_t mem_addr_i,
    input  logic  mem_we_i,
    input  be_t   mem_be_i,
    input  word_t mem_wdata_i,
    output logic  mem_rvalid_o,
    output logic  mem_err_o,
    output word_t mem_rdata_o,

    input  logic  uart_rx_i,
    output logic  uart_tx_o
);

    localparam addr_t MEM_MASK = addr_t'(RAM_SIZE - 1);

    logic  ram_req;
    logic  hwreg_req;
    logic  ram_rvalid;
    word_t ram_rdata;
    logic  hwreg_rvalid;
    word_t hwreg_rdata;
    logic  rvalid_q;

    // ########################################################################
    // Address decode and response
    // ########################################################################

    assign ram_req   = mem_req_i & ((mem_addr_i & ~MEM_MASK) == MEM_START);
    assign hwreg_req = mem_req_i & (mem_addr_i[31:16] == HWREG_PAGE);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_req_i;
        end
    end

    assign mem_rvalid_o = rvalid_q;
    // Neither slave answered the request
    assign mem_err_o    = rvalid_q & ~(ram_rvalid | hwreg_rvalid);
    assign mem_rdata_o  = hwreg_rvalid ? hwreg_rdata : ram_rdata;

    ram32 #(
        .WORDS    ( RAM_SIZE / 4 )
    ) i_ram (
        .clk_i    ( clk_i        ),
        .rst_n    ( rst_n        ),
        .req_i    ( ram_req      ),
        .we_i     ( mem_we_i     ),
        .be_i     ( mem_be_i     ),
        .addr_i   ( mem_addr_i   ),
        .wdata_i  ( mem_wdata_i  ),
        .rvalid_o ( ram_rvalid   ),
        .rdata_o  ( ram_rdata    )
    );

    hwreg_iface #(
        .CLK_FREQ     ( CLK_FREQ          ),
        .BAUD_RATE    ( BAUD_RATE         ),
        .RX_QUEUE_LEN ( RX_QUEUE_LEN      )
    ) i_hwregs (
        .clk_i        ( clk_i             ),
        .rst_n        ( rst_n             ),
        .req_i        ( hwreg_req         ),
        .we_i         ( mem_we_i          ),
        .addr_i       ( mem_addr_i[15:0]  ),
        .wdata_i      ( mem_wdata_i       ),
        .rvalid_o     ( hwreg_rvalid      ),
        .rdata_o      ( hwreg_rdata       ),
        .rx_i         ( uart_rx_i         ),
        .tx_o         ( uart_tx_o         )
    );

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n)
        !(ram_rvalid && hwreg_rvalid))
        else $error("demo_sys: RAM and register page answered together");

endmodule

//--- tb_uart_bfm.sv
// Serial line model for 8N1 frames, timed by the system clock
// Drives the line a fixed delay after the rising edge, samples on the falling edge

module tb_uart_bfm #(
    parameter int unsigned CLKS_PER_BIT = 16,
    parameter int          DRIVE_DLY    = 10
) (
    input  logic clk_i,
    input  logic serial_i,
    output logic serial_o
);

    initial begin
        serial_o = 1'b1;
    end

    // Start bit, eight data bits LSB first, stop bit, then one idle bit
    task automatic send_byte(input logic [7:0] data);
        logic [10:0] frame;
        frame = {2'b11, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            serial_o = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
        end
    endtask

    // found stays low when no start bit shows up within timeout_cycles
    task automatic recv_byte(input int timeout_cycles, output logic found,
                             output logic stop_ok, output logic [7:0] data);
        int n;
        found   = 1'b0;
        stop_ok = 1'b0;
        data    = '0;
        n       = 0;
        while (!found && n < timeout_cycles) begin
            @(negedge clk_i);
            found = (serial_i == 1'b0);
            n++;
        end
        if (found) begin
            // Move to the middle of the start bit, then step one bit at a time
            repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_i);
                data[i] = serial_i;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            stop_ok = serial_i;
        end
    endtask

endmodule

//--- tb_demo_sys.sv
// Testbench for demo_sys acting as bus master, with a serial model on the UART pins
// Assumes 16 clocks per bit and a 4 KiB RAM; each wait gives up after a fixed count

module tb_demo_sys import soc_pkg::*; ();

    localparam int unsigned CLK_FREQ     = 1_600_000;
    localparam int unsigned BAUD_RATE    = 100_000;
    localparam int unsigned RAM_SIZE     = 4096;
    localparam int unsigned RX_QUEUE_LEN = 8;
    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int unsigned RAM_IDX_W    = $clog2(RAM_SIZE / 4);
    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DLY    = 10;
    localparam int          RAM_CHECKS   = 16;
    localparam addr_t       DATA_ADDR    = {HWREG_PAGE, REG_UART_DATA};
    localparam addr_t       STATUS_ADDR  = {HWREG_PAGE, REG_UART_STATUS};

    logic        clk_i;
    logic        rst_n;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_we;
    be_t         mem_be;
    word_t       mem_wdata;
    logic        mem_rvalid;
    logic        mem_err;
    word_t       mem_rdata;
    logic        uart_rx;
    logic        uart_tx;

    string       test_name;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    logic        timed_out;
    logic [31:0] lfsr_state;

    demo_sys #(
        .CLK_FREQ     ( CLK_FREQ     ),
        .BAUD_RATE    ( BAUD_RATE    ),
        .RAM_SIZE     ( RAM_SIZE     ),
        .RX_QUEUE_LEN ( RX_QUEUE_LEN )
    ) i_dut (
        .clk_i        ( clk_i        ),
        .rst_n        ( rst_n        ),
        .mem_req_i    ( mem_req      ),
        .mem_addr_i   ( mem_addr     ),
        .mem_we_i     ( mem_we       ),
        .mem_be_i     ( mem_be       ),
        .mem_wdata_i  ( mem_wdata    ),
        .mem_rvalid_o ( mem_rvalid   ),
        .mem_err_o    ( mem_err      ),
        .mem_rdata_o  ( mem_rdata    ),
        .uart_rx_i    ( uart_rx      ),
        .uart_tx_o    ( uart_tx      )
    );

    tb_uart_bfm #(
        .CLKS_PER_BIT ( CLKS_PER_BIT ),
        .DRIVE_DLY    ( DRIVE_DLY    )
    ) i_bfm (
        .clk_i        ( clk_i        ),
        .serial_i     ( uart_tx      ),
        .serial_o     ( uart_rx      )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ########################################################################
    // Bus protocol checks
    // ########################################################################

    rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n)
        mem_req |=> mem_rvalid)
        else begin
            $display("[ERROR] %s: mem_rvalid_o after request expected 1, actual 0", test_name);
            err_cnt++;
        end

    rvalid_only_after_req: assert property (@(posedge clk_i) disable iff (!rst_n)
        !mem_req |=> !mem_rvalid)
        else begin
            $display("[ERROR] %s: mem_rvalid_o without request expected 0, actual 1", test_name);
            err_cnt++;
        end

    err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n)
        mem_err |-> mem_rvalid)
        else begin
            $display("[ERROR] %s: mem_rvalid_o with mem_err_o expected 1, actual 0", test_name);
            err_cnt++;
        end

    // ########################################################################
    // Helpers
    // ########################################################################

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        timed_out = 1'b1;
    endtask

    // One request cycle after an idle cycle; the response is taken one cycle later
    task automatic transfer(input logic we, input addr_t addr, input be_t be,
                            input word_t wdata, output word_t rdata, output logic err);
        @(posedge clk_i);
        #DRIVE_DLY;
        mem_req   = 1'b1;
        mem_we    = we;
        mem_addr  = addr;
        mem_be    = be;
        mem_wdata = wdata;
        @(posedge clk_i);
        #DRIVE_DLY;
        mem_req = 1'b0;
        mem_we  = 1'b0;
        rdata   = mem_rdata;
        err     = mem_err;
    endtask

    task automatic wait_status(input int bit_idx, input logic value, input int max_polls);
        word_t st;
        logic  err;
        logic  done;
        int    n;
        done = 1'b0;
        n    = 0;
        while (!done && n < max_polls) begin
            transfer(1'b0, STATUS_ADDR, 4'hF, '0, st, err);
            done = (st[bit_idx] == value);
            n++;
        end
        if (!done) begin
            note_timeout(value ? "a status bit to rise" : "a status bit to clear");
        end
    endtask

    task automatic check_frame(input logic found, input logic stop_ok,
                               input byte_t exp, input byte_t got);
        if (!found) begin
            note_timeout("a frame on uart_tx_o");
        end else begin
            expect_eq("stop bit", 32'd1, 32'(stop_ok));
            expect_eq("tx byte", 32'(exp), 32'(got));
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == err_mark && !timed_out) begin
            pass_cnt++;
            $display("PASS %s", test_name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", test_name);
        end
    endtask

    // ########################################################################
    // Tests
    // ########################################################################

    task automatic reset_values();
        word_t rd;
        logic  err;
        start_test("reset_values");
        expect_eq("uart_tx_o", 32'd1, 32'(uart_tx));
        transfer(1'b0, STATUS_ADDR, 4'hF, '0, rd, err);
        expect_eq("status", 32'd0, rd);
        transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
        expect_eq("data", RDATA_EMPTY, rd);
        finish_test();
    endtask

    task automatic ram_readback();
        int unsigned idx [RAM_CHECKS];
        word_t       model [RAM_SIZE / 4];
        logic [31:0] r;
        word_t       d;
        word_t       rd;
        be_t         be;
        logic        err;
        start_test("ram_readback");
        // Full writes first so every lane checked later holds a known value
        for (int k = 0; k < RAM_CHECKS; k++) begin
            rand_bits(RAM_IDX_W, r);
            idx[k] = r;
            rand_bits(32, d);
            transfer(1'b1, MEM_START + addr_t'(idx[k] * 4), 4'hF, d, rd, err);
            model[idx[k]] = d;
            expect_eq("write error flag", 32'd0, 32'(err));
        end
        for (int k = 0; k < RAM_CHECKS; k++) begin
            rand_bits(4, r);
            be = r[3:0];
            rand_bits(32, d);
            transfer(1'b1, MEM_START + addr_t'(idx[k] * 4), be, d, rd, err);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    model[idx[k]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
        for (int k = 0; k < RAM_CHECKS; k++) begin
            transfer(1'b0, MEM_START + addr_t'(idx[k] * 4), 4'hF, '0, rd, err);
            expect_eq("read data", model[idx[k]], rd);
            expect_eq("read error flag", 32'd0, 32'(err));
        end
        finish_test();
    endtask

    task automatic unmapped_access();
        word_t rd;
        logic  err;
        start_test("unmapped_access");
        transfer(1'b0, 32'h0001_0000, 4'hF, '0, rd, err);
        expect_eq("error flag on read", 32'd1, 32'(err));
        transfer(1'b1, 32'h8000_0040, 4'hF, 32'h1234_5678, rd, err);
        expect_eq("error flag on write", 32'd1, 32'(err));
        finish_test();
    endtask

    task automatic uart_transmit();
        word_t rd;
        logic  err;
        logic  found;
        logic  stop_ok;
        byte_t got;
        start_test("uart_transmit");
        fork
            i_bfm.recv_byte(4 * CLKS_PER_BIT, found, stop_ok, got);
            begin
                transfer(1'b1, DATA_ADDR, 4'h1, 32'h5A, rd, err);
                transfer(1'b0, STATUS_ADDR, 4'hF, '0, rd, err);
                expect_eq("busy after write", 32'd1, 32'(rd[0]));
            end
        join
        check_frame(found, stop_ok, 8'h5A, got);
        wait_status(0, 1'b0, 10 * CLKS_PER_BIT);
        // The write of 0x3C lands while the frame for 0xC3 is still going out
        if (!timed_out) begin
            fork
                i_bfm.recv_byte(4 * CLKS_PER_BIT, found, stop_ok, got);
                begin
                    transfer(1'b1, DATA_ADDR, 4'h1, 32'hC3, rd, err);
                    transfer(1'b0, STATUS_ADDR, 4'hF, '0, rd, err);
                    expect_eq("busy before second write", 32'd1, 32'(rd[0]));
                    transfer(1'b1, DATA_ADDR, 4'h1, 32'h3C, rd, err);
                end
            join
            check_frame(found, stop_ok, 8'hC3, got);
        end
        // Watch the line from the stop bit on, where a held byte would follow
        if (!timed_out) begin
            i_bfm.recv_byte(30 * CLKS_PER_BIT, found, stop_ok, got);
            expect_eq("frame from write while busy", 32'd0, 32'(found));
            wait_status(0, 1'b0, 10 * CLKS_PER_BIT);
        end
        finish_test();
    endtask

    task automatic uart_receive();
        byte_t msg [3];
        word_t rd;
        logic  err;
        msg = '{8'h11, 8'h7E, 8'hE8};
        start_test("uart_receive");
        for (int k = 0; k < 3; k++) begin
            i_bfm.send_byte(msg[k]);
        end
        wait_status(1, 1'b1, 4 * CLKS_PER_BIT);
        if (!timed_out) begin
            for (int k = 0; k < 3; k++) begin
                transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
                expect_eq("rx byte", 32'(msg[k]), rd);
            end
            transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
            expect_eq("data after last byte", RDATA_EMPTY, rd);
        end
        finish_test();
    endtask

    task automatic queue_overflow();
        byte_t       sent [RX_QUEUE_LEN + 1];
        logic [31:0] r;
        word_t       rd;
        logic        err;
        start_test("queue_overflow");
        for (int k = 0; k <= RX_QUEUE_LEN; k++) begin
            rand_bits(8, r);
            sent[k] = r[7:0];
            i_bfm.send_byte(sent[k]);
        end
        wait_status(1, 1'b1, 4 * CLKS_PER_BIT);
        // The last byte took the place of the newest one in the full queue
        if (!timed_out) begin
            for (int k = 0; k < RX_QUEUE_LEN - 1; k++) begin
                transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
                expect_eq("kept byte", 32'(sent[k]), rd);
            end
            transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
            expect_eq("last byte sent", 32'(sent[RX_QUEUE_LEN]), rd);
            transfer(1'b0, DATA_ADDR, 4'hF, '0, rd, err);
            expect_eq("data after drain", RDATA_EMPTY, rd);
        end
        finish_test();
    endtask

    // ########################################################################
    // Sequence
    // ########################################################################

    initial begin
        rst_n      = 1'b0;
        mem_req    = 1'b0;
        mem_addr   = '0;
        mem_we     = 1'b0;
        mem_be     = '0;
        mem_wdata  = '0;
        lfsr_state = 32'he5c4_98dd;
        err_cnt    = 0;
        err_mark   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        timed_out  = 1'b0;
        test_name  = "reset";
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n = 1'b1;

        reset_values();
        ram_readback();
        unmapped_access();
        if (!timed_out) uart_transmit();
        if (!timed_out) uart_receive();
        if (!timed_out) queue_overflow();

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
soc_pkg.sv
ram32.sv
uart_tx.sv
uart_rx.sv
uart_iface.sv
hwreg_iface.sv
demo_sys.sv
tb_uart_bfm.sv
tb_demo_sys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the demo_sys testbench with Verilator and runs it
# Exits non-zero when the build or the run fails, or when the log reports a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_demo_sys --Mdir obj_dir -o sim_tb \
    -f filelist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
